// File: Bender.yml
package:
  name: cobs_encoder

sources:
  - files:
      - source/cobs_pkg.sv
      - source/cobs_byte_fifo.sv
      - source/cobs_segmenter.sv
      - source/cobs_merger.sv
      - source/cobs_output_reg.sv
      - source/cobs_encoder.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/cobs_encoder_tb.sv

// File: source/cobs_byte_fifo.sv
// synchronous stream beat FIFO with a registered head entry and valid/ready ports
`timescale 1ns/1ps
`default_nettype none

module cobs_byte_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  cobs_pkg::stream_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output cobs_pkg::stream_beat_t out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);

    // pointers carry one extra wrap bit
    logic [cobs_pkg::FIFO_ADDR_W:0] wr_ptr;
    logic [cobs_pkg::FIFO_ADDR_W:0] rd_ptr;
    logic [cobs_pkg::FIFO_ADDR_W:0] fill;
    cobs_pkg::stream_beat_t         mem [cobs_pkg::FIFO_DEPTH];
    logic                           mem_empty;
    logic                           full;
    logic                           head_load;
    logic                           bypass;
    logic                           mem_wr;
    logic                           mem_rd;

    assign fill      = wr_ptr - rd_ptr;
    assign mem_empty = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[cobs_pkg::FIFO_ADDR_W] != rd_ptr[cobs_pkg::FIFO_ADDR_W])
                       && (wr_ptr[cobs_pkg::FIFO_ADDR_W-1:0] == rd_ptr[cobs_pkg::FIFO_ADDR_W-1:0]);
    assign in_ready  = !full;

    // head register refills when empty or popped
    assign head_load = !out_valid || out_ready;
    assign mem_rd    = head_load && !mem_empty;
    // with nothing stored, a write goes straight to the head register
    assign bypass    = head_load && mem_empty && in_valid;
    assign mem_wr    = in_valid && in_ready && !bypass;

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr[cobs_pkg::FIFO_ADDR_W-1:0]] <= in_beat;
        end
        if (mem_rd) begin
            out_beat <= mem[rd_ptr[cobs_pkg::FIFO_ADDR_W-1:0]];
        end else if (bypass) begin
            out_beat <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (head_load) begin
                out_valid <= mem_rd || bypass;
            end
        end
    end

    // stored entries never pass the depth, so no write slipped in while full
    assert property (@(posedge clk) disable iff (rst)
        fill <= cobs_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

// File: source/cobs_encoder.sv
// COBS encoder top level chaining segmenter, code and data FIFOs, merger and output register
`timescale 1ns/1ps
`default_nettype none

module cobs_encoder #(
    parameter bit append_zero = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cobs_pkg::stream_beat_t s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,
    output cobs_pkg::stream_beat_t m_beat,
    output logic                   m_valid,
    input  logic                   m_ready
);

    cobs_pkg::stream_beat_t code_in_beat;
    logic                   code_in_valid;
    logic                   code_in_ready;
    cobs_pkg::stream_beat_t data_in_beat;
    logic                   data_in_valid;
    logic                   data_in_ready;
    cobs_pkg::stream_beat_t code_out_beat;
    logic                   code_out_valid;
    logic                   code_out_ready;
    cobs_pkg::stream_beat_t data_out_beat;
    logic                   data_out_valid;
    logic                   data_out_ready;
    cobs_pkg::stream_beat_t merged_beat;
    logic                   merged_valid;
    logic                   merged_ready;

    cobs_segmenter #(
        .append_zero (append_zero)
    ) segmenter_i (
        .clk        (clk),
        .rst        (rst),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .code_beat  (code_in_beat),
        .code_valid (code_in_valid),
        .code_ready (code_in_ready),
        .data_beat  (data_in_beat),
        .data_valid (data_in_valid),
        .data_ready (data_in_ready)
    );

    // code bytes wait here until their data run is ready behind them
    cobs_byte_fifo code_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (code_in_beat),
        .in_valid  (code_in_valid),
        .in_ready  (code_in_ready),
        .out_beat  (code_out_beat),
        .out_valid (code_out_valid),
        .out_ready (code_out_ready)
    );

    cobs_byte_fifo data_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (data_in_beat),
        .in_valid  (data_in_valid),
        .in_ready  (data_in_ready),
        .out_beat  (data_out_beat),
        .out_valid (data_out_valid),
        .out_ready (data_out_ready)
    );

    cobs_merger merger_i (
        .clk          (clk),
        .rst          (rst),
        .code_beat    (code_out_beat),
        .code_valid   (code_out_valid),
        .code_ready   (code_out_ready),
        .data_beat    (data_out_beat),
        .data_valid   (data_out_valid),
        .data_ready   (data_out_ready),
        .merged_beat  (merged_beat),
        .merged_valid (merged_valid),
        .merged_ready (merged_ready)
    );

    cobs_output_reg output_reg_i (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (merged_beat),
        .in_valid (merged_valid),
        .in_ready (merged_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

endmodule

`default_nettype wire

// File: source/cobs_merger.sv
// COBS merge stage that emits each code beat followed by the data beats it announces
`timescale 1ns/1ps
`default_nettype none

module cobs_merger (
    input  logic                   clk,
    input  logic                   rst,
    input  cobs_pkg::stream_beat_t code_beat,
    input  logic                   code_valid,
    output logic                   code_ready,
    input  cobs_pkg::stream_beat_t data_beat,
    input  logic                   data_valid,
    output logic                   data_ready,
    output cobs_pkg::stream_beat_t merged_beat,
    output logic                   merged_valid,
    input  logic                   merged_ready
);

    cobs_pkg::merge_state_e state;
    cobs_pkg::merge_state_e state_next;
    cobs_pkg::run_count_t   count;
    cobs_pkg::run_count_t   count_next;

    always_comb begin
        state_next   = state;
        count_next   = count;
        code_ready   = 1'b0;
        data_ready   = 1'b0;
        merged_beat  = code_beat;
        merged_valid = 1'b0;

        case (state)
            cobs_pkg::merge_code: begin
                // error mark only leaves the encoder on the closing beat
                merged_beat.user = code_beat.user && code_beat.last;
                merged_valid     = code_valid;
                code_ready       = merged_ready;
                if (code_valid && merged_ready && code_beat.data > 8'd1 && !code_beat.user) begin
                    count_next = code_beat.data - 8'd1;
                    state_next = cobs_pkg::merge_data;
                end
            end
            cobs_pkg::merge_data: begin
                merged_beat  = data_beat;
                merged_valid = data_valid;
                data_ready   = merged_ready;
                if (data_valid && merged_ready) begin
                    count_next = count - 8'd1;
                    if (count == 8'd1) begin
                        state_next = cobs_pkg::merge_code;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::merge_code;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    // a data run always has bytes left to send
    assert property (@(posedge clk) disable iff (rst)
        (state == cobs_pkg::merge_data) |-> (count != '0));

endmodule

`default_nettype wire

// File: source/cobs_output_reg.sv
// two-entry skid register that drives the encoder output from registers
`timescale 1ns/1ps
`default_nettype none

module cobs_output_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  cobs_pkg::stream_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output cobs_pkg::stream_beat_t m_beat,
    output logic                   m_valid,
    input  logic                   m_ready
);

    cobs_pkg::stream_beat_t temp_beat;
    logic                   temp_valid;
    logic                   ready_early;

    // stay open if the sink drains or the temp slot cannot fill next cycle
    assign ready_early = m_ready || (!temp_valid && (!m_valid || !in_valid));

    always_ff @(posedge clk) begin
        if (in_ready) begin
            if (m_ready || !m_valid) begin
                m_beat <= in_beat;
            end else begin
                temp_beat <= in_beat;
            end
        end else if (m_ready) begin
            m_beat <= temp_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (in_ready) begin
                if (m_ready || !m_valid) begin
                    m_valid <= in_valid;
                end else begin
                    temp_valid <= in_valid;
                end
            end else if (m_ready) begin
                // drain the skid slot
                m_valid    <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/cobs_pkg.sv
// shared types, stream beat struct, state enums and FIFO constants of the COBS encoder
`default_nettype none

package cobs_pkg;

    // FIFO sizing, the depth is a power of two of the pointer width
    localparam int FIFO_DEPTH  = 256;
    localparam int FIFO_ADDR_W = 8;
    // longest run of data bytes that one code announces
    localparam int MAX_RUN     = 254;

    typedef logic [7:0] byte_t;
    // 0 is the delimiter, 1 a lone zero, 255 a full run
    typedef logic [7:0] code_t;
    typedef logic [7:0] run_count_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } stream_beat_t;

    typedef enum logic [1:0] {
        seg_idle,
        seg_segment,
        seg_final_code,
        seg_delimiter
    } seg_state_e;

    typedef enum logic {
        merge_code,
        merge_data
    } merge_state_e;

endpackage

`default_nettype wire

// File: source/cobs_segmenter.sv
// COBS input stage that counts non-zero runs and feeds the code and data FIFOs
`timescale 1ns/1ps
`default_nettype none

module cobs_segmenter #(
    parameter bit append_zero = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  cobs_pkg::stream_beat_t s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,
    output cobs_pkg::stream_beat_t code_beat,
    output logic                   code_valid,
    input  logic                   code_ready,
    output cobs_pkg::stream_beat_t data_beat,
    output logic                   data_valid,
    input  logic                   data_ready
);

    cobs_pkg::seg_state_e state;
    cobs_pkg::seg_state_e state_next;
    cobs_pkg::run_count_t count;
    cobs_pkg::run_count_t count_next;
    cobs_pkg::code_t      run;
    logic                 fail;
    logic                 fail_next;
    logic                 take;
    logic                 drop_byte;

    // input only flows while both FIFOs can take a beat
    assign s_ready = (state == cobs_pkg::seg_idle || state == cobs_pkg::seg_segment)
                     && code_ready && data_ready;
    assign take = s_valid && s_ready;

    // zero byte or errored last byte closes the run and is not stored
    assign drop_byte = (s_beat.data == '0) || (s_beat.last && s_beat.user);

    // code of the open run, one more than the bytes held
    assign run = (state == cobs_pkg::seg_idle) ? 8'd1 : count;

    always_comb begin
        state_next     = state;
        count_next     = count;
        fail_next      = fail;
        code_beat      = '0;
        code_valid     = 1'b0;
        data_beat      = '0;
        data_beat.data = s_beat.data;
        data_valid     = 1'b0;

        case (state)
            cobs_pkg::seg_idle, cobs_pkg::seg_segment: begin
                if (take && drop_byte) begin
                    code_beat.data = run;
                    code_valid     = 1'b1;
                    state_next     = cobs_pkg::seg_idle;
                    if (s_beat.last) begin
                        fail_next  = s_beat.user;
                        state_next = cobs_pkg::seg_final_code;
                    end
                end else if (take) begin
                    data_valid = 1'b1;
                    count_next = run + 8'd1;
                    state_next = cobs_pkg::seg_segment;
                    if (run == cobs_pkg::MAX_RUN) begin
                        // full run, code 255 and restart
                        code_beat.data = run + 8'd1;
                        code_valid     = 1'b1;
                        count_next     = 8'd1;
                    end
                    if (s_beat.last) begin
                        code_beat.data = run + 8'd1;
                        code_valid     = 1'b1;
                        if (append_zero) begin
                            state_next = cobs_pkg::seg_delimiter;
                        end else begin
                            data_beat.last = 1'b1;
                            state_next     = cobs_pkg::seg_idle;
                        end
                    end
                end
            end
            cobs_pkg::seg_final_code: begin
                // code 2 with user flags a failed frame for the merger
                code_beat.data = fail ? 8'd2 : 8'd1;
                code_beat.user = fail;
                code_beat.last = !append_zero;
                code_valid     = 1'b1;
                if (code_ready) begin
                    if (append_zero) begin
                        state_next = cobs_pkg::seg_delimiter;
                    end else begin
                        fail_next  = 1'b0;
                        state_next = cobs_pkg::seg_idle;
                    end
                end
            end
            cobs_pkg::seg_delimiter: begin
                code_beat.data = 8'd0;
                code_beat.last = 1'b1;
                code_beat.user = fail;
                code_valid     = 1'b1;
                if (code_ready) begin
                    fail_next  = 1'b0;
                    state_next = cobs_pkg::seg_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cobs_pkg::seg_idle;
            count <= '0;
            fail  <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            fail  <= fail_next;
        end
    end

    // open run code stays between 1 and MAX_RUN while segmenting
    assert property (@(posedge clk) disable iff (rst)
        (state == cobs_pkg::seg_segment) |-> (count != '0 && count <= cobs_pkg::MAX_RUN));

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
source/cobs_pkg.sv
source/cobs_byte_fifo.sv
source/cobs_segmenter.sv
source/cobs_merger.sv
source/cobs_output_reg.sv
source/cobs_encoder.sv
test/cobs_encoder_tb.sv

// File: include/cobs_ref_model.svh
// reference COBS encoding functions and queue types for the encoder testbench
`ifndef COBS_REF_MODEL_SVH
`define COBS_REF_MODEL_SVH

typedef cobs_pkg::byte_t        byte_q_t[$];
typedef cobs_pkg::stream_beat_t beat_q_t[$];

// appends a code beat and the run it announces, then empties the run
function automatic void flush_run(ref beat_q_t beats, ref byte_q_t run);
    cobs_pkg::stream_beat_t beat;
    beat = '0;
    beat.data = cobs_pkg::code_t'(run.size() + 1);
    beats.push_back(beat);
    foreach (run[i]) begin
        beat.data = run[i];
        beats.push_back(beat);
    end
    run.delete();
endfunction

// err marks the last byte of the frame with the error flag
function automatic beat_q_t encode_frame(byte_q_t bytes, bit err, bit append_zero);
    beat_q_t                beats;
    byte_q_t                run;
    cobs_pkg::stream_beat_t beat;
    bit                     last;
    beat = '0;
    foreach (bytes[i]) begin
        last = (i == bytes.size() - 1);
        if (bytes[i] == 8'h00 || (last && err)) begin
            flush_run(beats, run);
            if (last) begin
                // closing code, 2 for an errored frame
                beat.data = err ? 8'd2 : 8'd1;
                beats.push_back(beat);
            end
        end else begin
            run.push_back(bytes[i]);
            if (run.size() == cobs_pkg::MAX_RUN || last) begin
                flush_run(beats, run);
            end
        end
    end
    if (append_zero) begin
        beat.data = 8'h00;
        beat.last = 1'b1;
        beat.user = err;
        beats.push_back(beat);
    end else if (beats.size() > 0) begin
        beats[$].last = 1'b1;
        beats[$].user = err;
    end
    return beats;
endfunction

`endif

// File: test/cobs_encoder_tb.sv
// testbench for the COBS encoder with directed and random frames checked against a reference queue
`timescale 1ns/1ps
`default_nettype none

module cobs_encoder_tb;

    `include "cobs_ref_model.svh"

    logic                   clk;
    logic                   rst;
    cobs_pkg::stream_beat_t s_beat;
    logic                   s_valid;
    logic                   s_ready;
    cobs_pkg::stream_beat_t m_beat;
    logic                   m_valid;
    logic                   m_ready;

    beat_q_t                exp_q;
    cobs_pkg::stream_beat_t exp_head;
    logic                   exp_empty;
    logic                   idle_check;
    bit                     backpressure;
    int                     error_count;
    int                     test_count;
    int                     failed_tests;
    int                     beat_total;
    int                     cycles;

    cobs_encoder #(
        .append_zero (1'b1)
    ) cobs_encoder_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    always #10 clk = !clk;

    // each output transfer must match the head of the expected queue
    assert property (@(posedge clk) disable iff (rst)
        (m_valid && m_ready && !exp_empty) |-> (m_beat == exp_head))
    else begin
        $display("Mismatch at %0t: m_beat expected %h actual %h",
                 $time, $sampled(exp_head), $sampled(m_beat));
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        (m_valid && m_ready) |-> !exp_empty)
    else begin
        $display("at %0t an output beat arrived when no beat was expected", $time);
        error_count++;
    end

    // a stalled beat stays put until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else begin
        $display("at %0t the output beat changed or dropped before it was taken", $time);
        error_count++;
    end

    // zero bytes only as the closing delimiter, which alone carries last
    assert property (@(posedge clk) disable iff (rst)
        m_valid |-> ((m_beat.data == 8'h00) == m_beat.last))
    else begin
        $display("at %0t the last flag and a zero byte did not coincide", $time);
        error_count++;
    end

    assert property (@(posedge clk) disable iff (rst)
        idle_check |-> !m_valid)
    else begin
        $display("at %0t m_valid rose before any input was sent", $time);
        error_count++;
    end

    function automatic void refresh_head();
        exp_empty = (exp_q.size() == 0);
        exp_head  = exp_empty ? '0 : exp_q[0];
    endfunction

    always @(posedge clk) begin
        if (!rst && m_valid && m_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 4 * beat_total + 1000) begin
            $display("timeout after %0d cycles with %0d expected beats pending",
                     cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            #1;
            m_ready = backpressure ? ($urandom % 4 != 0) : 1'b1;
        end
    endtask

    // queues the expected encoding, then feeds the frame one byte at a time
    task automatic send_frame(input byte_q_t bytes, input bit err);
        beat_q_t expected;
        bit      taken;
        expected = encode_frame(bytes, err, 1'b1);
        beat_total += bytes.size() + expected.size();
        foreach (expected[i]) begin
            exp_q.push_back(expected[i]);
        end
        refresh_head();
        foreach (bytes[i]) begin
            s_beat      = '0;
            s_beat.data = bytes[i];
            s_beat.last = (i == bytes.size() - 1);
            s_beat.user = err && s_beat.last;
            s_valid     = 1'b1;
            taken       = 1'b0;
            // s_ready comes from registers, so it is steady at the falling edge
            while (!taken) begin
                @(negedge clk);
                taken = s_ready;
                @(posedge clk);
            end
            #1;
        end
        s_valid = 1'b0;
        s_beat  = '0;
    endtask

    task automatic random_frame(output byte_q_t bytes, output bit err);
        int len;
        int value;
        bytes.delete();
        len = 1 + ($urandom % 80);
        for (int i = 0; i < len; i++) begin
            value = $urandom % 256;
            if ($urandom % 4 == 0) begin
                value = 0;
            end
            bytes.push_back(8'(value));
        end
        err = ($urandom % 8 == 0);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: passed", test_count, name);
        end
    endtask

    initial begin
        byte_q_t bytes;
        bit      err;
        int      errs;
        clk          = 1'b0;
        rst          = 1'b1;
        s_valid      = 1'b0;
        s_beat       = '0;
        m_ready      = 1'b0;
        backpressure = 1'b0;
        idle_check   = 1'b0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        beat_total   = 0;
        cycles       = 0;
        refresh_head();
        void'($urandom(32'hdd28_f184));
        fork
            drive_ready();
        join_none
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        errs       = error_count;
        idle_check = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        idle_check = 1'b0;
        finish_test("idle after reset", errs);

        errs  = error_count;
        bytes = '{8'h11, 8'h22, 8'h33};
        send_frame(bytes, 1'b0);
        finish_test("short frame without zeros", errs);

        // leading, embedded, adjacent and trailing zeros
        errs  = error_count;
        bytes = '{8'h00, 8'h41};
        send_frame(bytes, 1'b0);
        bytes = '{8'h11, 8'h00, 8'h22, 8'h00, 8'h00, 8'h33};
        send_frame(bytes, 1'b0);
        bytes = '{8'h5a, 8'h6b, 8'h00};
        send_frame(bytes, 1'b0);
        bytes = '{8'h00};
        send_frame(bytes, 1'b0);
        finish_test("frames with zeros", errs);

        errs = error_count;
        bytes.delete();
        for (int i = 0; i < 600; i++) begin
            bytes.push_back(8'((i % 255) + 1));
        end
        send_frame(bytes, 1'b0);
        finish_test("long run", errs);

        errs  = error_count;
        bytes = '{8'h11, 8'h22, 8'h33};
        send_frame(bytes, 1'b1);
        bytes = '{8'h00, 8'h00};
        send_frame(bytes, 1'b1);
        finish_test("error frames", errs);

        errs         = error_count;
        backpressure = 1'b1;
        repeat (20) begin
            random_frame(bytes, err);
            send_frame(bytes, err);
        end
        finish_test("random frames with back-pressure", errs);

        // leave room for any stray beat to show up
        repeat (20) @(posedge clk);
        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
